// ==== hw/data_packet_path.sv ====
`timescale 1ns/100ps

module data_packet_path
   import usb_proto_pkg::*;
#(
   parameter int fifo_depth = 8
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       data_strobe,
   input  logic [7:0] route_byte,
   input  logic       route_eop,
   input  logic       r_enable,
   output logic [7:0] r_data,
   output logic       empty,
   output logic       data_ok_crc,
   output logic       data_short,
   output logic       data_overflow
);

   localparam int addr_w = $clog2(fifo_depth);

   logic [7:0]      mem [fifo_depth];
   // Extra MSB tells full from empty
   logic [addr_w:0] wr_ptr;
   logic [addr_w:0] rd_ptr;
   logic            full;
   logic            push;
   logic            pop;
   logic [15:0]     crc;
   // Last two bytes, possibly the CRC
   logic [7:0]      hold_new;
   logic [7:0]      hold_old;
   // Bytes in holdback, saturates at two
   logic [1:0]      held;
   logic            ovf_seen;

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                  (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

   // Oldest held byte leaves once the holdback is full
   assign push = data_strobe && (held == 2'd2);
   assign pop  = r_enable && !empty;

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr        <= '0;
         rd_ptr        <= '0;
         crc           <= '1;
         held          <= 2'd0;
         ovf_seen      <= 1'b0;
         data_ok_crc   <= 1'b0;
         data_short    <= 1'b0;
         data_overflow <= 1'b0;
      end else begin
         if (route_eop) begin
            // Results for this packet, then rearm
            data_ok_crc   <= (crc == crc16_residue);
            data_short    <= (held != 2'd2);
            data_overflow <= ovf_seen;
            crc           <= '1;
            held          <= 2'd0;
            ovf_seen      <= 1'b0;
         end else if (data_strobe) begin
            // CRC bytes are included for the residue
            crc <= crc16_byte(crc, route_byte);
            if (held != 2'd2)
               held <= held + 2'd1;
         end
         // Full FIFO drops the byte
         if (push) begin
            if (full)
               ovf_seen <= 1'b1;
            else
               wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // Holdback shift
   always_ff @(posedge clk) begin
      if (data_strobe) begin
         hold_old <= hold_new;
         hold_new <= route_byte;
      end
   end

   // Storage and registered read port
   always_ff @(posedge clk) begin
      if (push && !full)
         mem[wr_ptr[addr_w-1:0]] <= hold_old;
      if (pop)
         r_data <= mem[rd_ptr[addr_w-1:0]];
   end

endmodule

// ==== hw/pid_decode.sv ====
`timescale 1ns/100ps

module pid_decode
   import usb_proto_pkg::*, usb_rx_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic [7:0] rx_byte,
   input  logic       rx_strobe,
   input  logic       rx_eop,
   output logic       data_strobe,
   output logic       token_strobe,
   output logic [7:0] route_byte,
   output logic       route_eop,
   output pid_kind_t  pid_kind,
   output pid_code_t  pid_code,
   output logic       pid_error,
   output logic       pid_seen,
   output logic       extra_bytes
);

   route_state_t state;
   logic [3:0]   nib_hi;
   logic         nib_ok;
   pid_kind_t    kind_next;

   assign nib_hi = rx_byte[7:4];
   // Check field is the inverted code
   assign nib_ok = (rx_byte[3:0] == ~rx_byte[7:4]);

   // Group bits pick the kind
   always_comb begin
      case (nib_hi[1:0])
         grp_token:     kind_next = kind_token;
         grp_data:      kind_next = kind_data;
         grp_handshake: kind_next = kind_handshake;
         default:       kind_next = kind_special;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state        <= rt_wait_pid;
         data_strobe  <= 1'b0;
         token_strobe <= 1'b0;
         route_eop    <= 1'b0;
         pid_kind     <= kind_special;
         pid_code     <= pid_reserved;
         pid_error    <= 1'b0;
         pid_seen     <= 1'b0;
         extra_bytes  <= 1'b0;
      end else begin
         // Steer strobes by current route
         data_strobe  <= rx_strobe && (state == rt_data);
         token_strobe <= rx_strobe && (state == rt_token);
         route_eop    <= rx_eop;
         if (rx_eop) begin
            state <= rt_wait_pid;
            // Eop with no PID byte at all
            if (state == rt_wait_pid) begin
               pid_seen    <= 1'b0;
               pid_error   <= 1'b0;
               pid_kind    <= kind_special;
               pid_code    <= pid_reserved;
               extra_bytes <= 1'b0;
            end
         end else if (rx_strobe) begin
            case (state)
               rt_wait_pid: begin
                  // Kind is kept even for a bad PID
                  pid_seen    <= 1'b1;
                  pid_error   <= !nib_ok;
                  pid_kind    <= kind_next;
                  pid_code    <= pid_code_t'(nib_hi);
                  extra_bytes <= 1'b0;
                  if (!nib_ok)
                     state <= rt_drop;
                  else if (kind_next == kind_data)
                     state <= rt_data;
                  else if (kind_next == kind_token)
                     state <= rt_token;
                  else
                     state <= rt_drop;
               end
               rt_drop: begin
                  // Handshakes are PID only
                  if (pid_kind == kind_handshake)
                     extra_bytes <= 1'b1;
               end
               default: begin
               end
            endcase
         end
      end
   end

   // Byte rides along with the strobe
   always_ff @(posedge clk) begin
      if (rx_strobe)
         route_byte <= rx_byte;
   end

endmodule

// ==== hw/rx_status_merge.sv ====
`timescale 1ns/100ps

module rx_status_merge
   import usb_proto_pkg::*, usb_rx_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       route_eop,
   input  logic       pid_seen,
   input  pid_kind_t  pid_kind,
   input  pid_code_t  pid_code,
   input  logic       pid_error,
   input  logic       extra_bytes,
   input  logic       data_ok_crc,
   input  logic       data_short,
   input  logic       data_overflow,
   input  logic       tok_ok_crc,
   input  logic       tok_bad_length,
   input  logic [6:0] tok_addr,
   input  logic [3:0] tok_endp,
   output logic       packet_done,
   output pid_kind_t  packet_kind,
   output pid_code_t  packet_pid,
   output rx_status_t packet_status,
   output logic [6:0] token_addr,
   output logic [3:0] token_endp
);

   logic       eop_d;
   // PID facts latched at route_eop, before a new PID can land
   pid_kind_t  kind_q;
   pid_code_t  code_q;
   logic       err_q;
   logic       seen_q;
   logic       extra_q;
   logic       length_err;
   logic       crc_err;
   rx_status_t status_next;

   always_ff @(posedge clk) begin
      if (route_eop) begin
         kind_q  <= pid_kind;
         code_q  <= pid_code;
         err_q   <= pid_error;
         seen_q  <= pid_seen;
         extra_q <= extra_bytes;
      end
   end

   // Only the path matching the kind counts
   assign length_err = !seen_q ||
                       ((kind_q == kind_data) && data_short) ||
                       ((kind_q == kind_token) && tok_bad_length) ||
                       ((kind_q == kind_handshake) && extra_q);
   assign crc_err    = ((kind_q == kind_data) && !data_ok_crc) ||
                       ((kind_q == kind_token) && !tok_ok_crc);

   // Highest priority first
   always_comb begin
      if (err_q)
         status_next = st_pid_error;
      else if (length_err)
         status_next = st_length_error;
      else if ((kind_q == kind_data) && data_overflow)
         status_next = st_overflow;
      else if (crc_err)
         status_next = st_crc_error;
      else
         status_next = st_ok;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         eop_d         <= 1'b0;
         packet_done   <= 1'b0;
         packet_kind   <= kind_special;
         packet_pid    <= pid_reserved;
         packet_status <= st_ok;
         token_addr    <= 7'd0;
         token_endp    <= 4'd0;
      end else begin
         // Path results are valid one cycle after route_eop
         eop_d       <= route_eop;
         packet_done <= eop_d;
         if (eop_d) begin
            packet_kind   <= kind_q;
            packet_pid    <= code_q;
            packet_status <= status_next;
            // Token fields hold for other kinds
            if (seen_q && !err_q && (kind_q == kind_token)) begin
               token_addr <= tok_addr;
               token_endp <= tok_endp;
            end
         end
      end
   end

endmodule

// ==== hw/token_packet_path.sv ====
`timescale 1ns/100ps

module token_packet_path
   import usb_proto_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       token_strobe,
   input  logic [7:0] route_byte,
   input  logic       route_eop,
   output logic       tok_ok_crc,
   output logic       tok_bad_length,
   output logic [6:0] tok_addr,
   output logic [3:0] tok_endp
);

   logic [4:0] crc;
   // Saturates at three so long packets stay flagged
   logic [1:0] count;
   logic [6:0] addr_q;
   logic [3:0] endp_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         crc            <= '1;
         count          <= 2'd0;
         tok_ok_crc     <= 1'b0;
         tok_bad_length <= 1'b0;
      end else begin
         if (route_eop) begin
            tok_ok_crc     <= (crc == crc5_residue);
            tok_bad_length <= (count != 2'd2);
            crc            <= '1;
            count          <= 2'd0;
         end else if (token_strobe) begin
            // All sixteen bits, CRC field too
            crc <= crc5_byte(crc, route_byte);
            if (count != 2'd3)
               count <= count + 2'd1;
         end
      end
   end

   // Fields arrive bit 0 first
   // Byte 0 is addr[6:0] and endp[0]
   // Byte 1 holds endp[3:1], then the CRC5
   always_ff @(posedge clk) begin
      if (token_strobe) begin
         case (count)
            2'd0: begin
               addr_q    <= route_byte[6:0];
               endp_q[0] <= route_byte[7];
            end
            2'd1: begin
               endp_q[3:1] <= route_byte[2:0];
            end
            default: begin
            end
         endcase
      end
   end

   // Snapshot at eop
   always_ff @(posedge clk) begin
      if (route_eop) begin
         tok_addr <= addr_q;
         tok_endp <= endp_q;
      end
   end

endmodule

// ==== hw/usb_proto_pkg.sv ====
package usb_proto_pkg;

   // PID code from the upper nibble of the PID byte
   // Lower nibble must carry the complement
   typedef enum logic [3:0] {
      // Tokens
      pid_out      = 4'b0001,
      pid_in       = 4'b1001,
      pid_sof      = 4'b0101,
      pid_setup    = 4'b1101,
      // Data
      pid_data0    = 4'b0011,
      pid_data1    = 4'b1011,
      pid_data2    = 4'b0111,
      pid_mdata    = 4'b1111,
      // Handshakes
      pid_ack      = 4'b0010,
      pid_nak      = 4'b1010,
      pid_stall    = 4'b1110,
      pid_nyet     = 4'b0110,
      // Specials
      pid_pre      = 4'b1100,
      pid_split    = 4'b1000,
      pid_ping     = 4'b0100,
      pid_reserved = 4'b0000
   } pid_code_t;

   // Low two bits of the code give the group
   localparam logic [1:0] grp_special   = 2'b00;
   localparam logic [1:0] grp_token     = 2'b01;
   localparam logic [1:0] grp_handshake = 2'b10;
   localparam logic [1:0] grp_data      = 2'b11;

   // Token CRC, x^5+x^2+1
   localparam logic [4:0]  crc5_poly     = 5'b00101;
   localparam logic [4:0]  crc5_residue  = 5'b01100;
   // Data CRC, x^16+x^15+x^2+1
   localparam logic [15:0] crc16_poly    = 16'h8005;
   localparam logic [15:0] crc16_residue = 16'h800D;

   // One byte into the CRC5 register, bit 0 first
   function automatic logic [4:0] crc5_byte(input logic [4:0] crc, input logic [7:0] b);
      logic [4:0] c;
      logic       fb;
      c = crc;
      for (int i = 0; i < 8; i++) begin
         fb = b[i] ^ c[4];
         c  = {c[3:0], 1'b0} ^ (fb ? crc5_poly : 5'b00000);
      end
      return c;
   endfunction

   // One byte into the CRC16 register, bit 0 first
   function automatic logic [15:0] crc16_byte(input logic [15:0] crc, input logic [7:0] b);
      logic [15:0] c;
      logic        fb;
      c = crc;
      for (int i = 0; i < 8; i++) begin
         fb = b[i] ^ c[15];
         c  = {c[14:0], 1'b0} ^ (fb ? crc16_poly : 16'h0000);
      end
      return c;
   endfunction

endpackage

// ==== hw/usb_rx_decode.sv ====
`timescale 1ns/100ps

module usb_rx_decode
   import usb_proto_pkg::*, usb_rx_pkg::*;
#(
   parameter int fifo_depth = 8
) (
   input  logic       clk,
   input  logic       reset,
   input  logic [7:0] rx_byte,
   input  logic       rx_strobe,
   input  logic       rx_eop,
   input  logic       r_enable,
   output logic [7:0] r_data,
   output logic       empty,
   output logic       packet_done,
   output pid_kind_t  packet_kind,
   output pid_code_t  packet_pid,
   output rx_status_t packet_status,
   output logic [6:0] token_addr,
   output logic [3:0] token_endp
);

   // Routing outputs
   logic       data_strobe;
   logic       token_strobe;
   logic [7:0] route_byte;
   logic       route_eop;
   pid_kind_t  pid_kind;
   pid_code_t  pid_code;
   logic       pid_error;
   logic       pid_seen;
   logic       extra_bytes;

   // Path results
   logic       data_ok_crc;
   logic       data_short;
   logic       data_overflow;
   logic       tok_ok_crc;
   logic       tok_bad_length;
   logic [6:0] tok_addr;
   logic [3:0] tok_endp;

   pid_decode u_pid_decode (
      .clk          (clk),
      .reset        (reset),
      .rx_byte      (rx_byte),
      .rx_strobe    (rx_strobe),
      .rx_eop       (rx_eop),
      .data_strobe  (data_strobe),
      .token_strobe (token_strobe),
      .route_byte   (route_byte),
      .route_eop    (route_eop),
      .pid_kind     (pid_kind),
      .pid_code     (pid_code),
      .pid_error    (pid_error),
      .pid_seen     (pid_seen),
      .extra_bytes  (extra_bytes)
   );

   // Payload store sized here
   data_packet_path #(
      .fifo_depth (fifo_depth)
   ) u_data_path (
      .clk           (clk),
      .reset         (reset),
      .data_strobe   (data_strobe),
      .route_byte    (route_byte),
      .route_eop     (route_eop),
      .r_enable      (r_enable),
      .r_data        (r_data),
      .empty         (empty),
      .data_ok_crc   (data_ok_crc),
      .data_short    (data_short),
      .data_overflow (data_overflow)
   );

   token_packet_path u_token_path (
      .clk            (clk),
      .reset          (reset),
      .token_strobe   (token_strobe),
      .route_byte     (route_byte),
      .route_eop      (route_eop),
      .tok_ok_crc     (tok_ok_crc),
      .tok_bad_length (tok_bad_length),
      .tok_addr       (tok_addr),
      .tok_endp       (tok_endp)
   );

   rx_status_merge u_status_merge (
      .clk            (clk),
      .reset          (reset),
      .route_eop      (route_eop),
      .pid_seen       (pid_seen),
      .pid_kind       (pid_kind),
      .pid_code       (pid_code),
      .pid_error      (pid_error),
      .extra_bytes    (extra_bytes),
      .data_ok_crc    (data_ok_crc),
      .data_short     (data_short),
      .data_overflow  (data_overflow),
      .tok_ok_crc     (tok_ok_crc),
      .tok_bad_length (tok_bad_length),
      .tok_addr       (tok_addr),
      .tok_endp       (tok_endp),
      .packet_done    (packet_done),
      .packet_kind    (packet_kind),
      .packet_pid     (packet_pid),
      .packet_status  (packet_status),
      .token_addr     (token_addr),
      .token_endp     (token_endp)
   );

endmodule

// ==== hw/usb_rx_pkg.sv ====
package usb_rx_pkg;

   // Packet class reported with every packet
   typedef enum logic [1:0] {
      kind_token     = 2'd0,
      kind_data      = 2'd1,
      kind_handshake = 2'd2,
      kind_special   = 2'd3
   } pid_kind_t;

   // Report result, one per packet
   typedef enum logic [2:0] {
      st_ok           = 3'd0,
      st_pid_error    = 3'd1,
      st_length_error = 3'd2,
      st_overflow     = 3'd3,
      st_crc_error    = 3'd4
   } rx_status_t;

   // Where the bytes after the PID go
   typedef enum logic [1:0] {
      rt_wait_pid = 2'd0,
      rt_data     = 2'd1,
      rt_token    = 2'd2,
      rt_drop     = 2'd3
   } route_state_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module usb_rx_decode_tb -f verilog.f -o usb_rx_sim \
   && ./obj_dir/usb_rx_sim | tee /dev/stderr | grep -q "TEST PASSED" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
   parameter int half_period = 4
) (
   output logic clk,
   output logic reset
);

   // Free running clock, 8 ns period
   initial begin
      clk = 1'b0;
      forever #(half_period) clk = ~clk;
   end

   // Reset held for two rising edges
   initial begin
      reset = 1'b1;
      repeat (2) @(posedge clk);
      #1 reset = 1'b0;
   end

endmodule

// ==== tb/usb_rx_decode_chk.sv ====
`timescale 1ns/100ps

module usb_rx_decode_chk (
   input logic clk,
   input logic reset,
   input logic route_eop,
   input logic packet_done,
   input logic store,
   input logic empty
);

   // Failures seen, read by the testbench top
   int   fail_count = 0;
   // Set by the first byte written into the FIFO
   logic stored_any;

   always_ff @(posedge clk) begin
      if (reset)
         stored_any <= 1'b0;
      else if (store)
         stored_any <= 1'b1;
   end

   // Report comes two cycles after the delayed eop
   done_after_eop: assert property (@(posedge clk) disable iff (reset)
      route_eop |-> ##2 packet_done)
      else begin
         fail_count = fail_count + 1;
         $error("packet_done missing two cycles after route_eop");
      end

   // No report without the eop that caused it
   done_has_cause: assert property (@(posedge clk) disable iff (reset)
      packet_done |-> $past(route_eop, 2))
      else begin
         fail_count = fail_count + 1;
         $error("packet_done without route_eop two cycles before");
      end

   // Single cycle pulse
   done_one_cycle: assert property (@(posedge clk) disable iff (reset)
      packet_done |=> !packet_done)
      else begin
         fail_count = fail_count + 1;
         $error("packet_done high for two cycles");
      end

   // FIFO stays empty until something is written
   empty_until_store: assert property (@(posedge clk) disable iff (reset)
      !stored_any |-> empty)
      else begin
         fail_count = fail_count + 1;
         $error("FIFO not empty before any byte was stored");
      end

endmodule

// Report timing lives in the merge block
bind rx_status_merge usb_rx_decode_chk u_chk (
   .clk         (clk),
   .reset       (reset),
   .route_eop   (route_eop),
   .packet_done (packet_done),
   .store       (1'b0),
   .empty       (1'b1)
);

// FIFO state lives in the data path
bind data_packet_path usb_rx_decode_chk u_chk (
   .clk         (clk),
   .reset       (reset),
   .route_eop   (1'b0),
   .packet_done (1'b0),
   .store       (push && !full),
   .empty       (empty)
);

// ==== tb/usb_rx_decode_monitor.sv ====
`timescale 1ns/100ps

module usb_rx_decode_monitor
   import usb_proto_pkg::*, usb_rx_pkg::*;
(
   input logic       clk,
   input logic       reset,
   input logic       packet_done,
   input pid_kind_t  packet_kind,
   input pid_code_t  packet_pid,
   input rx_status_t packet_status,
   input logic [6:0] token_addr,
   input logic [3:0] token_endp,
   input logic       r_enable,
   input logic [7:0] r_data,
   input logic       empty
);

   // Expected report of the running test
   pid_kind_t  exp_kind;
   pid_code_t  exp_pid;
   rx_status_t exp_status;
   logic [6:0] exp_addr;
   logic [3:0] exp_endp;
   // Payload still to be read, oldest first
   logic [7:0] exp_q[$];
   logic       armed = 1'b0;
   logic       got_report = 1'b0;
   // Pop seen last edge, data due now
   logic       pop_d = 1'b0;
   int         test_errors = 0;
   int         error_count = 0;
   int         tests_ok = 0;
   int         tests_bad = 0;

   task automatic count_error();
      test_errors = test_errors + 1;
      error_count = error_count + 1;
   endtask

   task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
         count_error();
      end
   endtask

   task automatic expect_report(input pid_kind_t k, input pid_code_t p, input rx_status_t s,
                                input logic [6:0] a, input logic [3:0] e, input logic tok);
      exp_kind    = k;
      exp_pid     = p;
      exp_status  = s;
      // Token fields keep the last token's values for other kinds
      if (tok) begin
         exp_addr = a;
         exp_endp = e;
      end
      exp_q.delete();
      got_report  = 1'b0;
      test_errors = 0;
      armed       = 1'b1;
   endtask

   task automatic expect_byte(input logic [7:0] b);
      exp_q.push_back(b);
   endtask

   // Closes a test and prints its line
   task automatic end_test(input int idx);
      if (!got_report) begin
         $display("ERROR at %0t: no packet report arrived for test %0d", $time, idx);
         count_error();
      end
      if (exp_q.size() != 0) begin
         $display("ERROR at %0t: %0d payload bytes were never read", $time, exp_q.size());
         count_error();
      end
      if (test_errors == 0) begin
         $display("test %0d: ok", idx);
         tests_ok = tests_ok + 1;
      end else begin
         $display("test %0d: %0d errors", idx, test_errors);
         tests_bad = tests_bad + 1;
      end
      armed = 1'b0;
   endtask

   always @(posedge clk) begin
      if (reset) begin
         pop_d = 1'b0;
      end else begin
         if (packet_done) begin
            if (!armed || got_report) begin
               $display("ERROR at %0t: packet report with no packet sent", $time);
               count_error();
            end else begin
               got_report = 1'b1;
               check_val("packet_kind", 8'(packet_kind), 8'(exp_kind));
               check_val("packet_pid", 8'(packet_pid), 8'(exp_pid));
               check_val("packet_status", 8'(packet_status), 8'(exp_status));
               check_val("token_addr", 8'(token_addr), 8'(exp_addr));
               check_val("token_endp", 8'(token_endp), 8'(exp_endp));
            end
         end
         if (pop_d) begin
            if (exp_q.size() == 0) begin
               $display("ERROR at %0t: byte %0h read with no payload left", $time, r_data);
               count_error();
            end else begin
               check_val("r_data", r_data, exp_q.pop_front());
            end
         end
         pop_d = r_enable && !empty;
      end
   end

endmodule

// ==== tb/usb_rx_decode_tb.sv ====
`timescale 1ns/100ps

module usb_rx_decode_tb
   import usb_proto_pkg::*, usb_rx_pkg::*;
;

   localparam int fifo_depth  = 8;
   localparam int n_tests     = 16;
   // Worst case bytes, gaps and draining per packet
   localparam int cycle_limit = n_tests * (13 * 4 + fifo_depth + 10);

   // CRC handling of a table entry
   localparam int crc_none    = 0;
   localparam int crc_good    = 1;
   localparam int crc_corrupt = 2;

   logic       clk;
   logic       reset;
   logic [7:0] rx_byte;
   logic       rx_strobe;
   logic       rx_eop;
   logic       r_enable;
   logic [7:0] r_data;
   logic       empty;
   logic       packet_done;
   pid_kind_t  packet_kind;
   pid_code_t  packet_pid;
   rx_status_t packet_status;
   logic [6:0] token_addr;
   logic [3:0] token_endp;

   // Packet table
   logic        t_has_pid [n_tests];
   logic [7:0]  t_pid     [n_tests];
   int          t_nf      [n_tests];
   logic [95:0] t_fields  [n_tests];
   int          t_crc     [n_tests];
   pid_kind_t   t_kind    [n_tests];
   rx_status_t  t_status  [n_tests];
   logic [6:0]  t_addr    [n_tests];
   logic [3:0]  t_endp    [n_tests];
   int          t_npay    [n_tests];
   int          n_entries = 0;

   int seed;
   int cycles = 0;

   tb_clock_gen u_clock (
      .clk   (clk),
      .reset (reset)
   );

   usb_rx_decode #(
      .fifo_depth (fifo_depth)
   ) dut (
      .clk           (clk),
      .reset         (reset),
      .rx_byte       (rx_byte),
      .rx_strobe     (rx_strobe),
      .rx_eop        (rx_eop),
      .r_enable      (r_enable),
      .r_data        (r_data),
      .empty         (empty),
      .packet_done   (packet_done),
      .packet_kind   (packet_kind),
      .packet_pid    (packet_pid),
      .packet_status (packet_status),
      .token_addr    (token_addr),
      .token_endp    (token_endp)
   );

   usb_rx_decode_monitor mon (
      .clk           (clk),
      .reset         (reset),
      .packet_done   (packet_done),
      .packet_kind   (packet_kind),
      .packet_pid    (packet_pid),
      .packet_status (packet_status),
      .token_addr    (token_addr),
      .token_endp    (token_endp),
      .r_enable      (r_enable),
      .r_data        (r_data),
      .empty         (empty)
   );

   task automatic add_packet(input logic has_pid, input logic [7:0] pid, input int nf,
                             input logic [95:0] f, input int crc, input pid_kind_t k,
                             input rx_status_t s, input logic [6:0] a, input logic [3:0] e,
                             input int npay);
      t_has_pid[n_entries] = has_pid;
      t_pid[n_entries]     = pid;
      t_nf[n_entries]      = nf;
      t_fields[n_entries]  = f;
      t_crc[n_entries]     = crc;
      t_kind[n_entries]    = k;
      t_status[n_entries]  = s;
      t_addr[n_entries]    = a;
      t_endp[n_entries]    = e;
      t_npay[n_entries]    = npay;
      n_entries            = n_entries + 1;
   endtask

   // Address, endpoint and CRC5 as sent, bit 0 first
   function automatic logic [15:0] token_word(input logic [6:0] a, input logic [3:0] e,
                                              input logic bad);
      logic [15:0] w;
      logic [4:0]  c;
      logic        fb;
      w = {5'b00000, e, a};
      c = 5'b11111;
      for (int i = 0; i < 11; i++) begin
         fb = w[i] ^ c[4];
         c  = {c[3:0], 1'b0} ^ (fb ? crc5_poly : 5'b00000);
      end
      // Inverted register, high bit on the wire first
      for (int i = 0; i < 5; i++)
         w[11 + i] = ~c[4 - i];
      if (bad)
         w[15] = ~w[15];
      return w;
   endfunction

   // The two CRC16 bytes for a payload, first byte in bits 7:0
   function automatic logic [15:0] data_crc(input logic [7:0] d[$]);
      logic [15:0] c;
      logic [15:0] r;
      logic        fb;
      c = 16'hFFFF;
      foreach (d[j]) begin
         for (int i = 0; i < 8; i++) begin
            fb = d[j][i] ^ c[15];
            c  = {c[14:0], 1'b0} ^ (fb ? crc16_poly : 16'h0000);
         end
      end
      for (int i = 0; i < 16; i++)
         r[i] = ~c[15 - i];
      return r;
   endfunction

   task automatic drive_cycle(input logic strobe, input logic [7:0] b, input logic eop);
      @(posedge clk);
      #1;
      rx_strobe = strobe;
      rx_eop    = eop;
      if (strobe)
         rx_byte = b;
   endtask

   task automatic send_packet(input int t);
      logic [7:0]  pkt[$];
      logic [7:0]  pay[$];
      logic [15:0] w;
      int          gap;
      if (t_has_pid[t])
         pkt.push_back(t_pid[t]);
      for (int j = 0; j < t_nf[t]; j++)
         pay.push_back(t_fields[t][8 * j +: 8]);
      if (t_crc[t] != crc_none && t_kind[t] == kind_token) begin
         w = token_word(t_addr[t], t_endp[t], t_crc[t] == crc_corrupt);
         pkt.push_back(w[7:0]);
         pkt.push_back(w[15:8]);
      end else begin
         foreach (pay[j])
            pkt.push_back(pay[j]);
         if (t_crc[t] != crc_none) begin
            w = data_crc(pay);
            // One flipped bit spoils the CRC
            if (t_crc[t] == crc_corrupt)
               w[0] = ~w[0];
            pkt.push_back(w[7:0]);
            pkt.push_back(w[15:8]);
         end
      end
      foreach (pkt[j]) begin
         drive_cycle(1'b1, pkt[j], 1'b0);
         gap = {$random(seed)} % 4;
         repeat (gap) drive_cycle(1'b0, 8'h00, 1'b0);
      end
      drive_cycle(1'b0, 8'h00, 1'b1);
      drive_cycle(1'b0, 8'h00, 1'b0);
   endtask

   task automatic drain_fifo();
      forever begin
         @(posedge clk);
         #1;
         if (empty) begin
            r_enable = 1'b0;
            break;
         end
         r_enable = 1'b1;
      end
      // Last registered byte reaches the monitor
      repeat (2) @(posedge clk);
      #1;
   endtask

   // Hard stop on a hung run
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("Timeout after %0d cycles, packet report or FIFO never settled", cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   initial begin
      int chk_fails;
      rx_byte   = 8'h00;
      rx_strobe = 1'b0;
      rx_eop    = 1'b0;
      r_enable  = 1'b0;
      seed      = 11;

      // Tokens with CRC5
      add_packet(1, 8'h1E, 0, 96'h0, crc_good, kind_token, st_ok, 7'h05, 4'h1, 0);
      add_packet(1, 8'h96, 0, 96'h0, crc_good, kind_token, st_ok, 7'h7F, 4'hF, 0);
      add_packet(1, 8'hD2, 0, 96'h0, crc_good, kind_token, st_ok, 7'h2A, 4'h0, 0);
      add_packet(1, 8'h5A, 0, 96'h0, crc_good, kind_token, st_ok, 7'h33, 4'h6, 0);
      add_packet(1, 8'h1E, 0, 96'h0, crc_corrupt, kind_token, st_crc_error, 7'h09, 4'h2, 0);
      // Data with CRC16
      add_packet(1, 8'h3C, 4, 96'h44332211, crc_good, kind_data, st_ok, 7'h0, 4'h0, 4);
      add_packet(1, 8'hB4, 0, 96'h0, crc_good, kind_data, st_ok, 7'h0, 4'h0, 0);
      add_packet(1, 8'hB4, 5, 96'hA5A4A3A2A1, crc_corrupt, kind_data, st_crc_error,
                 7'h0, 4'h0, 5);
      // Handshakes and a broken PID
      add_packet(1, 8'h2D, 0, 96'h0, crc_none, kind_handshake, st_ok, 7'h0, 4'h0, 0);
      add_packet(1, 8'hA5, 1, 96'h55, crc_none, kind_handshake, st_length_error,
                 7'h0, 4'h0, 0);
      add_packet(1, 8'h2C, 0, 96'h0, crc_none, kind_handshake, st_pid_error, 7'h0, 4'h0, 0);
      // Ten bytes into an eight byte FIFO
      add_packet(1, 8'h3C, 10, 96'h0A090807060504030201, crc_good, kind_data, st_overflow,
                 7'h0, 4'h0, fifo_depth);
      // Empty packet, short data, specials
      add_packet(0, 8'h00, 0, 96'h0, crc_none, kind_special, st_length_error, 7'h0, 4'h0, 0);
      add_packet(1, 8'h3C, 1, 96'h5C, crc_none, kind_data, st_length_error, 7'h0, 4'h0, 0);
      add_packet(1, 8'hC3, 0, 96'h0, crc_none, kind_special, st_ok, 7'h0, 4'h0, 0);
      add_packet(1, 8'hE1, 0, 96'h0, crc_none, kind_handshake, st_ok, 7'h0, 4'h0, 0);

      wait (reset === 1'b1);
      wait (reset === 1'b0);

      for (int t = 0; t < n_entries; t++) begin
         mon.expect_report(t_kind[t],
                           t_has_pid[t] ? pid_code_t'(t_pid[t][7:4]) : pid_reserved,
                           t_status[t], t_addr[t], t_endp[t], t_kind[t] == kind_token);
         for (int j = 0; j < t_npay[t]; j++)
            mon.expect_byte(t_fields[t][8 * j +: 8]);
         send_packet(t);
         // Timeout above covers a report that never comes
         do @(posedge clk); while (!packet_done);
         drain_fifo();
         mon.end_test(t);
      end

      chk_fails = dut.u_status_merge.u_chk.fail_count + dut.u_data_path.u_chk.fail_count;
      $display("%0d tests, %0d ok, %0d failed, %0d check errors, %0d assertion failures",
               n_entries, mon.tests_ok, mon.tests_bad, mon.error_count, chk_fails);
      if (mon.error_count == 0 && chk_fails == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== verilog.f ====
hw/usb_proto_pkg.sv
hw/usb_rx_pkg.sv
hw/pid_decode.sv
hw/data_packet_path.sv
hw/token_packet_path.sv
hw/rx_status_merge.sv
hw/usb_rx_decode.sv
tb/tb_clock_gen.sv
tb/usb_rx_decode_chk.sv
tb/usb_rx_decode_monitor.sv
tb/usb_rx_decode_tb.sv
